/* verilog/gpif_cfg.svh */
// Build-time sizing; FIFO depth must stay a power of two and above the read pipeline slack
`ifndef GPIF_CFG_SVH
`define GPIF_CFG_SVH

// Bus and stream width
`define GPIF_DATA_W           32

// FX3 endpoint addresses on fifoadr
`define GPIF_ADDR_DATA_RX     2'd0   // FPGA reads from here
`define GPIF_ADDR_DATA_TX     2'd1   // FPGA writes to here

// Sequencer timing
`define GPIF_SETTLE_CYCLES    8      // Flags settle after fifoadr moves
`define GPIF_FLUSH_CYCLES     2      // Idle strobes after a write burst
`define GPIF_USB_PKT_WORDS    256    // Native USB packet, drives the pad rule
`define GPIF_XFER_W           16

// Local FIFO sizing
`define GPIF_FIFO_DEPTH       64
`define GPIF_NEAR_FULL_SLACK  6      // Words still in flight when a burst is cut
`define GPIF_RX_ROOM_WORDS    32

`endif

/* verilog/gpif_pkg.sv */
// Types shared by the bus master; state encoding is 3 bits and is visible to the bound checks
`include "gpif_cfg.svh"

package gpif_pkg;

    //////////////////////////////////////////////////
    // Bus master states
    //////////////////////////////////////////////////
    typedef enum logic [2:0] {
        IDLE        = 3'd0,  // Park strobes, step to other endpoint
        WAIT        = 3'd1,  // Local check plus settle count
        THINK       = 3'd2,  // Decide from resampled FX3 flags
        READ        = 3'd3,  // slrd held low
        READ_FLUSH  = 3'd4,  // Drain strobe pipeline
        WRITE       = 3'd5,  // slwr low per word
        WRITE_FLUSH = 3'd6   // Hold address, strobes idle
    } gpif_state_t;

    //////////////////////////////////////////////////
    // Data words
    //////////////////////////////////////////////////
    // Same width on the FX3 bus and both local streams
    typedef logic [`GPIF_DATA_W-1:0] gpif_word_t;

endpackage

/* verilog/stream_fifo.sv */
// First-word-fall-through FIFO; DEPTH must be a power of two, flags lag the count by one cycle
`timescale 1ns/100ps

module stream_fifo #(
    parameter int DEPTH           = 64,
    parameter int NEAR_FULL_SLACK = 6,
    parameter int ROOM_WORDS      = 32
) (
    input  logic                 gpif_clk,
    input  logic                 gpif_rst,
    input  gpif_pkg::gpif_word_t s_tdata,
    input  logic                 s_tlast,
    input  logic                 s_tvalid,
    output logic                 s_tready,
    output gpif_pkg::gpif_word_t m_tdata,
    output logic                 m_tlast,
    output logic                 m_tvalid,
    input  logic                 m_tready,
    output logic                 nearly_full,
    output logic                 has_space
);

    localparam int PTR_W  = $clog2(DEPTH);
    localparam int CNT_W  = $clog2(DEPTH + 1);
    localparam int WORD_W = $bits(gpif_pkg::gpif_word_t);

    logic [WORD_W:0]   mem [DEPTH];     // {last, data}
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic [CNT_W-1:0]  free_words;
    logic              wr_en;
    logic              rd_en;

    assign wr_en      = s_tvalid && s_tready;
    assign rd_en      = m_tvalid && m_tready;
    assign s_tready   = (count != CNT_W'(DEPTH));
    assign m_tvalid   = (count != '0);
    assign m_tdata    = mem[rd_ptr][WORD_W-1:0];  // Head word shows without a read
    assign m_tlast    = mem[rd_ptr][WORD_W];
    assign free_words = CNT_W'(DEPTH) - count;

    always_ff @(posedge gpif_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= {s_tlast, s_tdata};
        end
    end

    // Pointers wrap on the power-of-two depth
    always_ff @(posedge gpif_clk) begin
        if (gpif_rst) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            nearly_full <= 1'b0;
            has_space   <= 1'b0;
        end else begin
            wr_ptr      <= wr_ptr + PTR_W'(wr_en);
            rd_ptr      <= rd_ptr + PTR_W'(rd_en);
            count       <= count + CNT_W'(wr_en) - CNT_W'(rd_en);
            nearly_full <= (free_words <= CNT_W'(NEAR_FULL_SLACK));  // Stop bursts early
            has_space   <= (free_words >= CNT_W'(ROOM_WORDS));
        end
    end

endmodule

/* verilog/gpif_capture_stage.sv */
// Input side of the bus; FX3 must place read data on gpif_d_in while slrd2 is low
`timescale 1ns/100ps

module gpif_capture_stage (
    input  logic                 gpif_clk,
    input  logic                 gpif_rst,
    input  logic [1:0]           gpif_ctl,
    input  gpif_pkg::gpif_word_t gpif_d_in,
    input  logic                 slrd,
    input  logic                 read_active,
    input  logic                 rd_eop,
    output logic                 fx3_ready,
    output logic                 fx3_wmark,
    output logic                 slrd3,
    output gpif_pkg::gpif_word_t tx_in_tdata,
    output logic                 tx_in_tlast,
    output logic                 tx_in_tvalid
);

    logic ready_pad;    // First flag stage, lands in the I/O pad
    logic wmark_pad;
    logic slrd1;
    logic slrd2;
    logic rd_eop1;
    logic rd_eop2;

    //////////////////////////////////////////////////
    // FX3 flags, two stages for timing closure
    //////////////////////////////////////////////////
    always_ff @(posedge gpif_clk) begin
        if (gpif_rst) begin
            ready_pad <= 1'b0;
            wmark_pad <= 1'b0;
            fx3_ready <= 1'b0;
            fx3_wmark <= 1'b0;
        end else begin
            ready_pad <= gpif_ctl[0];
            wmark_pad <= gpif_ctl[1];
            fx3_ready <= ready_pad;
            fx3_wmark <= wmark_pad;
        end
    end

    //////////////////////////////////////////////////
    // Strobe and end-of-packet delay lines
    //////////////////////////////////////////////////
    always_ff @(posedge gpif_clk) begin
        if (gpif_rst) begin
            {slrd1, slrd2, slrd3} <= 3'b111;  // Strobes idle high
            rd_eop1 <= 1'b0;
            rd_eop2 <= 1'b0;
        end else begin
            {slrd1, slrd2, slrd3} <= {slrd, slrd1, slrd2};
            rd_eop1 <= rd_eop;
            rd_eop2 <= rd_eop1;  // Lines up with slrd3 of the last word
        end
    end

    // Bus word taken only when a read is in flight, held otherwise
    always_ff @(posedge gpif_clk) begin
        if (!slrd2) begin
            tx_in_tdata <= gpif_d_in;
        end
    end

    assign tx_in_tvalid = !slrd3 && read_active;
    assign tx_in_tlast  = rd_eop2;  // Watermark end only, a full FIFO gives no tlast

endmodule

/* verilog/gpif_sequencer.sv */
// FX3 slave-FIFO bus master for one endpoint pair; assumes FX3 flags two cycles old on entry
`timescale 1ns/100ps
`include "gpif_cfg.svh"

module gpif_sequencer (
    input  logic                 gpif_clk,
    input  logic                 gpif_rst,
    input  logic                 fx3_ready,
    input  logic                 fx3_wmark,
    input  logic                 slrd3,
    input  logic                 tx_nearly_full,
    input  logic                 tx_has_space,
    input  gpif_pkg::gpif_word_t rx_tdata,
    input  logic                 rx_tlast,
    input  logic                 rx_tvalid,
    output logic                 slrd,
    output logic                 slwr,
    output logic                 pktend,
    output logic                 sloe,
    output logic [1:0]           fifoadr,
    output gpif_pkg::gpif_word_t gpif_d_out,
    output logic                 read_active,
    output logic                 rd_eop,
    output logic                 rx_tready
);

    localparam int IDLE_W = $clog2(`GPIF_SETTLE_CYCLES);
    localparam int PKT_W  = $clog2(`GPIF_USB_PKT_WORDS);
    localparam logic [IDLE_W-1:0] SETTLE_LAST = IDLE_W'(`GPIF_SETTLE_CYCLES - 1);
    localparam logic [IDLE_W-1:0] FLUSH_IDLE  =
        IDLE_W'(`GPIF_SETTLE_CYCLES - `GPIF_FLUSH_CYCLES);
    localparam logic [IDLE_W-1:0] FLUSH_LAST  = FLUSH_IDLE - 1'b1;  // Last word still going out

    gpif_pkg::gpif_state_t   state;
    logic [IDLE_W-1:0]       idle_cycles;     // Settle count, then flush count
    logic [1:0]              next_addr;
    logic                    local_ready;
    logic                    read_ready_go;   // One cycle old
    logic                    write_ready_go;
    logic                    read_go;
    logic                    write_go;
    logic                    do_beat;
    logic                    wr_xfer;
    logic                    pkt_boundary;
    logic                    first_read;      // Covers the gap before slrd3 first drops
    logic                    pad;
    logic [`GPIF_XFER_W-1:0] transfer_size;

    //////////////////////////////////////////////////
    // Endpoint selection and local readiness
    //////////////////////////////////////////////////
    assign next_addr = (fifoadr == `GPIF_ADDR_DATA_RX) ? `GPIF_ADDR_DATA_TX : `GPIF_ADDR_DATA_RX;
    assign local_ready = (tx_has_space && (fifoadr == `GPIF_ADDR_DATA_RX)) ||
                         (rx_tvalid && (fifoadr == `GPIF_ADDR_DATA_TX));

    always_ff @(posedge gpif_clk) begin
        read_ready_go  <= tx_has_space && (fifoadr == `GPIF_ADDR_DATA_RX);
        write_ready_go <= rx_tvalid && (fifoadr == `GPIF_ADDR_DATA_TX);
    end

    assign read_go  = fx3_ready && fx3_wmark && read_ready_go;
    assign write_go = fx3_ready && write_ready_go && !read_go;

    // RX FIFO pop: first beat from THINK, then sustained while watermark holds
    assign rx_tready = (((state == gpif_pkg::WRITE) && fx3_wmark && !pad) ||
                        ((state == gpif_pkg::THINK) && write_go)) &&
                       (fifoadr == `GPIF_ADDR_DATA_TX);
    assign wr_xfer      = rx_tvalid && rx_tready;
    assign pkt_boundary = (transfer_size[PKT_W-1:0] == '0);  // Word count is a USB multiple
    assign do_beat      = (state == gpif_pkg::WRITE) || ((state == gpif_pkg::THINK) && write_go);
    assign read_active  = (state == gpif_pkg::READ) || (state == gpif_pkg::READ_FLUSH);

    //////////////////////////////////////////////////
    // Bus master FSM
    //////////////////////////////////////////////////
    always_ff @(posedge gpif_clk) begin
        if (gpif_rst) begin
            state         <= gpif_pkg::IDLE;
            {slrd, slwr, pktend, sloe} <= 4'b1111;
            fifoadr       <= `GPIF_ADDR_DATA_RX;
            gpif_d_out    <= '0;
            idle_cycles   <= '0;
            rd_eop        <= 1'b0;
            first_read    <= 1'b0;
            pad           <= 1'b0;
            transfer_size <= `GPIF_XFER_W'(1);
        end else begin
            case (state)
                gpif_pkg::IDLE: begin
                    {slrd, slwr, pktend, sloe} <= 4'b1111;
                    gpif_d_out  <= '0;
                    fifoadr     <= next_addr;    // Alternate endpoints
                    idle_cycles <= '0;
                    rd_eop      <= 1'b0;
                    first_read  <= 1'b0;
                    state       <= gpif_pkg::WAIT;
                end
                gpif_pkg::WAIT: begin
                    if (local_ready) begin
                        idle_cycles <= idle_cycles + 1'b1;
                        if (idle_cycles == SETTLE_LAST) state <= gpif_pkg::THINK;
                    end else begin
                        idle_cycles <= '0;       // Nothing to do here, try the other one
                        fifoadr     <= next_addr;
                    end
                end
                gpif_pkg::THINK: begin
                    idle_cycles <= '0;
                    if (read_go) begin
                        slrd       <= 1'b0;
                        sloe       <= 1'b0;      // FX3 drives the bus
                        first_read <= 1'b1;
                        state      <= gpif_pkg::READ;
                    end else if (!write_go) begin
                        state <= gpif_pkg::IDLE;
                    end
                end
                gpif_pkg::READ: begin
                    if (!fx3_wmark || tx_nearly_full) begin
                        slrd  <= 1'b1;           // Cut the burst, data still in flight
                        state <= gpif_pkg::READ_FLUSH;
                    end
                    if (!fx3_wmark) rd_eop <= 1'b1;  // True packet end
                    if (!slrd3) first_read <= 1'b0;
                end
                gpif_pkg::READ_FLUSH: begin
                    rd_eop <= 1'b0;
                    if (!slrd3) first_read <= 1'b0;
                    if (!first_read && slrd3) begin  // Strobe pipeline empty
                        sloe  <= 1'b1;
                        state <= gpif_pkg::IDLE;
                    end
                end
                gpif_pkg::WRITE_FLUSH: begin
                    {slrd, slwr, pktend} <= 3'b111;
                    gpif_d_out  <= '0;
                    idle_cycles <= idle_cycles + 1'b1;
                    if (idle_cycles == SETTLE_LAST) state <= gpif_pkg::IDLE;
                end
                default: ;                       // WRITE handled by the beat logic below
            endcase

            // Write beat, shared by the first word from THINK and the rest of the burst
            if (do_beat) begin
                gpif_d_out <= pad ? '0 : rx_tdata;
                if (pad) begin
                    {slwr, pktend} <= 2'b00;     // Pad word closes the packet
                    pad            <= 1'b0;
                    transfer_size  <= `GPIF_XFER_W'(1);
                    idle_cycles    <= FLUSH_LAST;
                    state          <= gpif_pkg::WRITE_FLUSH;
                end else if (wr_xfer && rx_tlast && pkt_boundary) begin
                    {slwr, pktend} <= 2'b01;     // Full USB packet, pad follows
                    pad            <= 1'b1;
                    transfer_size  <= transfer_size + 1'b1;
                    state          <= gpif_pkg::WRITE;
                end else if (wr_xfer && rx_tlast) begin
                    {slwr, pktend} <= 2'b00;     // Short packet, pktend with last word
                    transfer_size  <= `GPIF_XFER_W'(1);
                    idle_cycles    <= FLUSH_LAST;
                    state          <= gpif_pkg::WRITE_FLUSH;
                end else if (wr_xfer) begin
                    {slwr, pktend} <= 2'b01;
                    transfer_size  <= transfer_size + 1'b1;
                    state          <= gpif_pkg::WRITE;
                end else begin
                    {slwr, pktend} <= 2'b11;     // Watermark or local data ran out
                    idle_cycles    <= FLUSH_IDLE;
                    state          <= gpif_pkg::WRITE_FLUSH;
                end
            end
        end
    end

endmodule

/* verilog/gpif_slave_fifo_top.sv */
// Slave-FIFO master top; gpif_d_in/gpif_d_out and sloe need an external tristate pad buffer
`timescale 1ns/100ps
`include "gpif_cfg.svh"

module gpif_slave_fifo_top (
    input  logic                 gpif_clk,
    input  logic                 gpif_rst,
    input  logic [3:0]           gpif_ctl,     // Only ready and watermark used
    input  gpif_pkg::gpif_word_t gpif_d_in,
    output gpif_pkg::gpif_word_t gpif_d_out,
    output logic                 sloe,
    output logic                 slrd,
    output logic                 slwr,
    output logic                 pktend,
    output logic [1:0]           fifoadr,
    output gpif_pkg::gpif_word_t tx_tdata,
    output logic                 tx_tlast,
    output logic                 tx_tvalid,
    input  logic                 tx_tready,
    input  gpif_pkg::gpif_word_t rx_tdata,
    input  logic                 rx_tlast,
    input  logic                 rx_tvalid,
    output logic                 rx_tready
);

    logic                 fx3_ready, fx3_wmark, slrd3;
    logic                 read_active, rd_eop;
    gpif_pkg::gpif_word_t tx_in_tdata;            // Capture stage to TX FIFO
    logic                 tx_in_tlast, tx_in_tvalid;
    logic                 tx_nearly_full, tx_has_space;
    gpif_pkg::gpif_word_t rx_out_tdata;           // RX FIFO to sequencer
    logic                 rx_out_tlast, rx_out_tvalid, rx_out_tready;

    //////////////////////////////////////////////////
    // FX3 facing stages
    //////////////////////////////////////////////////
    gpif_capture_stage capture (
        .gpif_clk, .gpif_rst, .gpif_ctl(gpif_ctl[1:0]), .gpif_d_in, .slrd,
        .read_active, .rd_eop, .fx3_ready, .fx3_wmark, .slrd3,
        .tx_in_tdata, .tx_in_tlast, .tx_in_tvalid
    );

    gpif_sequencer sequencer (
        .gpif_clk, .gpif_rst, .fx3_ready, .fx3_wmark, .slrd3,
        .tx_nearly_full, .tx_has_space,
        .rx_tdata(rx_out_tdata), .rx_tlast(rx_out_tlast), .rx_tvalid(rx_out_tvalid),
        .slrd, .slwr, .pktend, .sloe, .fifoadr, .gpif_d_out,
        .read_active, .rd_eop, .rx_tready(rx_out_tready)
    );

    //////////////////////////////////////////////////
    // Local FIFOs
    //////////////////////////////////////////////////
    // Toward tx_*, the capture stage never sees back-pressure
    stream_fifo #(
        .DEPTH(`GPIF_FIFO_DEPTH), .NEAR_FULL_SLACK(`GPIF_NEAR_FULL_SLACK),
        .ROOM_WORDS(`GPIF_RX_ROOM_WORDS)
    ) tx_fifo (
        .gpif_clk, .gpif_rst,
        .s_tdata(tx_in_tdata), .s_tlast(tx_in_tlast), .s_tvalid(tx_in_tvalid), .s_tready(),
        .m_tdata(tx_tdata), .m_tlast(tx_tlast), .m_tvalid(tx_tvalid), .m_tready(tx_tready),
        .nearly_full(tx_nearly_full), .has_space(tx_has_space)
    );

    // From rx_*, drained by the write bursts
    stream_fifo #(
        .DEPTH(`GPIF_FIFO_DEPTH), .NEAR_FULL_SLACK(`GPIF_NEAR_FULL_SLACK),
        .ROOM_WORDS(`GPIF_RX_ROOM_WORDS)
    ) rx_fifo (
        .gpif_clk, .gpif_rst,
        .s_tdata(rx_tdata), .s_tlast(rx_tlast), .s_tvalid(rx_tvalid), .s_tready(rx_tready),
        .m_tdata(rx_out_tdata), .m_tlast(rx_out_tlast), .m_tvalid(rx_out_tvalid),
        .m_tready(rx_out_tready), .nearly_full(), .has_space()
    );

endmodule

/* verif/gpif_slave_fifo_asserts.sv */
// Bound into gpif_sequencer; all checks are disabled while gpif_rst is high
`timescale 1ns/100ps

module gpif_slave_fifo_asserts (
    input logic       gpif_clk,
    input logic       gpif_rst,
    input logic       slrd,
    input logic       slwr,
    input logic       sloe,
    input logic       slrd3,
    input logic [1:0] fifoadr
);

    //////////////////////////////////////////////////
    // Strobe rules on the FX3 bus
    //////////////////////////////////////////////////
    strobes_exclusive: assert property (@(posedge gpif_clk) disable iff (gpif_rst)
        !(!slrd && !slwr)) else $error("slrd and slwr low together");

    // FX3 keeps driving until the last strobe has left the pipeline
    sloe_covers_pipe: assert property (@(posedge gpif_clk) disable iff (gpif_rst)
        !slrd3 |-> !sloe) else $error("sloe high while slrd3 low");

    addr_held: assert property (@(posedge gpif_clk) disable iff (gpif_rst)
        (!slrd || !slwr) |=> $stable(fifoadr)) else $error("fifoadr moved under a strobe");

endmodule

bind gpif_sequencer gpif_slave_fifo_asserts asserts (
    .gpif_clk(gpif_clk), .gpif_rst(gpif_rst), .slrd(slrd), .slwr(slwr), .sloe(sloe),
    .slrd3(slrd3), .fifoadr(fifoadr)
);

/* verif/gpif_slave_fifo_tb.sv */
// Testbench for the slave-FIFO master; FX3 model drops watermark a fixed lead before packet end
`timescale 1ns/100ps
`include "gpif_cfg.svh"

module gpif_slave_fifo_tb;

    //////////////////////////////////////////////////
    // Test table, one row per test
    //////////////////////////////////////////////////
    localparam int NUM_TESTS = 6;
    localparam int RD_LEN [NUM_TESTS]     = '{0, 40, 120, 0, 0, 50};   // FX3 read packet
    localparam int WR_LEN [NUM_TESTS]     = '{0, 0, 0, 37, 256, 70};   // rx_* packet
    localparam int STALL [NUM_TESTS]      = '{0, 0, 300, 0, 0, 0};     // tx_tready low cycles
    localparam int WMARK_LEAD [NUM_TESTS] = '{3, 3, 3, 3, 3, 3};       // Strobes after drop

    logic                 gpif_clk, gpif_rst, sloe, slrd, slwr, pktend;
    logic [3:0]           gpif_ctl;
    logic [1:0]           fifoadr;
    gpif_pkg::gpif_word_t gpif_d_in, gpif_d_out, tx_tdata, rx_tdata;
    logic                 tx_tlast, tx_tvalid, tx_tready, rx_tlast, rx_tvalid, rx_tready;

    gpif_pkg::gpif_word_t rd_q[$], exp_rd[$], got_tx[$], exp_wr[$], got_wr[$];
    logic                 got_tx_last[$], got_pktend[$];
    logic [32:0]          rx_q[$];                // {last, data}
    gpif_pkg::gpif_word_t rd_stage;               // FX3 read pipeline
    logic [31:0]          lfsr_state = 32'h8e651954;
    int                   wmark_lead = 3;
    int                   stall_left = 0;
    int                   errors = 0;
    int                   tests_passed = 0;
    int                   tests_failed = 0;

    gpif_slave_fifo_top dut (
        .gpif_clk, .gpif_rst, .gpif_ctl, .gpif_d_in, .gpif_d_out, .sloe, .slrd, .slwr,
        .pktend, .fifoadr, .tx_tdata, .tx_tlast, .tx_tvalid, .tx_tready,
        .rx_tdata, .rx_tlast, .rx_tvalid, .rx_tready
    );

    always #2 gpif_clk = ~gpif_clk;

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_word(output logic [31:0] w);
        for (int i = 0; i < 32; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            w = {w[30:0], lfsr_state[0]};       // One step per bit
        end
    endtask

    //////////////////////////////////////////////////
    // FX3 slave-FIFO model
    //////////////////////////////////////////////////
    always @(posedge gpif_clk) begin
        gpif_pkg::gpif_word_t d_next;
        d_next = rd_stage;                       // Popped one edge ago
        if (!slrd) begin
            compare_value("fifoadr", `GPIF_ADDR_DATA_RX, fifoadr);  // Reads come from endpoint 0
            if (rd_q.size() > 0) begin
                rd_stage = rd_q.pop_front();
            end else begin
                $display("read strobe on an empty FX3 endpoint at %t", $realtime);
                errors++;
            end
        end
        if (!slwr) begin
            compare_value("fifoadr", `GPIF_ADDR_DATA_TX, fifoadr);
            got_wr.push_back(gpif_d_out);
            got_pktend.push_back(pktend);
        end
        #0.5;
        gpif_d_in = d_next;
        if (fifoadr == `GPIF_ADDR_DATA_RX)       // Flags follow the addressed endpoint
            gpif_ctl = {2'b00, rd_q.size() > wmark_lead, rd_q.size() != 0};
        else
            gpif_ctl = 4'b0011;                  // Write endpoint never fills
    end

    // tx_* sink with stall window
    always @(posedge gpif_clk) begin
        if (tx_tvalid && tx_tready) begin
            got_tx.push_back(tx_tdata);
            got_tx_last.push_back(tx_tlast);
        end
        #0.5;
        tx_tready = (stall_left == 0);
        if (stall_left > 0) stall_left--;
    end

    // rx_* source
    always @(posedge gpif_clk) begin
        if (rx_tvalid && rx_tready) rx_q.delete(0);
        #0.5;
        rx_tvalid = (rx_q.size() > 0);
        if (rx_q.size() > 0) begin
            rx_tdata = rx_q[0][31:0];
            rx_tlast = rx_q[0][32];
        end
    end

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
        if (got !== exp) begin
            $display("CHECK FAILED at %t: %s expected %h got %h", $realtime, name, exp, got);
            errors++;
        end
    endtask

    task automatic check_idle(input int cycles);
        repeat (cycles) begin
            @(posedge gpif_clk);
            compare_value("slrd", 1, slrd);
            compare_value("slwr", 1, slwr);
            compare_value("pktend", 1, pktend);
            compare_value("sloe", 1, sloe);
            compare_value("tx_tvalid", 0, tx_tvalid);
        end
    endtask

    task automatic load_test(input int row);
        logic [31:0] w;
        exp_rd.delete();
        got_tx.delete();
        got_tx_last.delete();
        exp_wr.delete();
        got_wr.delete();
        got_pktend.delete();
        for (int i = 0; i < RD_LEN[row]; i++) begin
            random_word(w);
            exp_rd.push_back(w);
            rd_q.push_back(w);
        end
        for (int i = 0; i < WR_LEN[row]; i++) begin
            random_word(w);
            exp_wr.push_back(w);
            rx_q.push_back({i == WR_LEN[row] - 1, w});
        end
        if (WR_LEN[row] > 0 && WR_LEN[row] % `GPIF_USB_PKT_WORDS == 0)
            exp_wr.push_back('0);                // Pad word
    endtask

    task automatic check_results();
        if (got_tx.size() != exp_rd.size()) begin
            $display("tx_* carried %0d words, %0d expected", got_tx.size(), exp_rd.size());
            errors++;
        end
        for (int i = 0; i < got_tx.size() && i < exp_rd.size(); i++) begin
            compare_value($sformatf("tx_tdata[%0d]", i), exp_rd[i], got_tx[i]);
            compare_value($sformatf("tx_tlast[%0d]", i), i == exp_rd.size() - 1, got_tx_last[i]);
        end
        if (got_wr.size() != exp_wr.size()) begin
            $display("FX3 took %0d writes, %0d expected", got_wr.size(), exp_wr.size());
            errors++;
        end
        for (int i = 0; i < got_wr.size() && i < exp_wr.size(); i++) begin
            compare_value($sformatf("gpif_d_out[%0d]", i), exp_wr[i], got_wr[i]);
            compare_value($sformatf("pktend[%0d]", i), i != exp_wr.size() - 1, got_pktend[i]);
        end
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////
    initial begin
        $timeformat(-9, 1, " ns", 0);
        {gpif_clk, gpif_rst, gpif_ctl, gpif_d_in, rd_stage} = '0;
        gpif_rst  = 1'b1;
        tx_tready = 1'b1;
        {rx_tdata, rx_tlast, rx_tvalid} = '0;
        repeat (3) @(posedge gpif_clk);
        #0.5 gpif_rst = 1'b0;
        for (int row = 0; row < NUM_TESTS; row++) begin
            @(negedge gpif_clk);
            errors     = 0;
            wmark_lead = WMARK_LEAD[row];
            stall_left = STALL[row];
            load_test(row);
            if (RD_LEN[row] == 0 && WR_LEN[row] == 0) begin
                check_idle(60);                  // Nothing queued, bus must stay parked
            end else begin
                while (got_tx.size() < exp_rd.size() || got_wr.size() < exp_wr.size())
                    @(posedge gpif_clk);
                repeat (50) @(posedge gpif_clk); // Catch stray extra words
                check_results();
            end
            if (errors == 0) tests_passed++;
            else tests_failed++;
            $display("test %0d read %0d write %0d stall %0d: %s", row, RD_LEN[row],
                     WR_LEN[row], STALL[row], (errors == 0) ? "passed" : "failed");
        end
        $display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // Watchdog sized from the table
    initial begin
        int total;
        total = 0;
        for (int row = 0; row < NUM_TESTS; row++) total += RD_LEN[row] + WR_LEN[row];
        repeat (total * 40 + 2000) @(posedge gpif_clk);
        $display("watchdog expired after %0d cycles, a test never completed", total * 40 + 2000);
        $display("Test FAILED");
        $finish;
    end

endmodule

/* sim.f */
+incdir+verilog
verilog/gpif_pkg.sv
verilog/stream_fifo.sv
verilog/gpif_capture_stage.sv
verilog/gpif_sequencer.sv
verilog/gpif_slave_fifo_top.sv
verif/gpif_slave_fifo_asserts.sv
verif/gpif_slave_fifo_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the slave-FIFO testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sim.f \
    --top-module gpif_slave_fifo_tb -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test FAILED" sim.log; then
    exit 1
fi
exit 0
